// File: verilog/gpu_cmd_pkg.sv
// Command-side definitions shared by the GPU host interface.
// Holds the host word type, the opcode encoding seen on recv_instr
// and how many parameter words follow each opcode on in_data.
// Import into a module body, or use scoped names in port lists.

`default_nettype none

package gpu_cmd_pkg;

    // one host or memory word
    typedef logic [31:0] word_t;

    // opcodes arrive as full 32-bit words
    typedef enum logic [31:0] {
        NOP           = 32'd0,
        COPY_TO_GPU   = 32'd1,
        COPY_FROM_GPU = 32'd2,
        KERNEL_LAUNCH = 32'd3
    } cmd_op_e;

    // widest parameter list of any command
    localparam int unsigned MAX_PARAMS = 2;

    // slot index into captured parameters
    typedef logic [$clog2(MAX_PARAMS)-1:0] param_idx_t;

    // byte address, then byte count
    localparam int unsigned COPY_PARAMS = 2;
    // kernel byte address only
    localparam int unsigned LAUNCH_PARAMS = 1;

    // zero means the opcode is not accepted (NOP or unknown)
    function automatic int unsigned param_count(cmd_op_e op);
        case (op)
            COPY_TO_GPU:   return COPY_PARAMS;
            COPY_FROM_GPU: return COPY_PARAMS;
            KERNEL_LAUNCH: return LAUNCH_PARAMS;
            default:       return 0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verilog/gpu_mem_pkg.sv
// Memory-side definitions for the GPU global memory.
// The host talks in byte addresses; the memory stores whole words,
// so these constants convert between the two views.

`default_nettype none

package gpu_mem_pkg;

    // host byte address
    typedef logic [31:0] byte_addr_t;

    // bytes in one memory word
    localparam byte_addr_t BYTES_PER_WORD = 32'd4;

    // low byte-address bits dropped to get a word index
    localparam int unsigned WORD_SHIFT = 2;

    // word index before folding into the memory depth
    typedef logic [31-WORD_SHIFT:0] word_idx_t;

endpackage

`default_nettype wire

// File: verilog/controller.sv
// Command controller for the GPU host interface.
// Takes an opcode on recv_instr while idle, gathers its parameter words
// from in_data, then runs the command: copy host words into global memory,
// stream memory words back on out_data, or launch a kernel and wait for
// kernel_done. busy is high for the whole command.

`default_nettype none

module controller (
    input  logic                    clk,
    input  logic                    rst,
    input  gpu_cmd_pkg::word_t      recv_instr,
    input  gpu_cmd_pkg::word_t      in_data,
    input  logic                    kernel_done,
    input  gpu_cmd_pkg::word_t      rd_data,
    output gpu_cmd_pkg::word_t      out_data,
    output logic                    out_valid,
    output logic                    busy,
    output logic                    launch,
    output gpu_mem_pkg::byte_addr_t kernel_addr,
    output logic                    wr_en,
    output gpu_mem_pkg::byte_addr_t wr_addr,
    output gpu_cmd_pkg::word_t      wr_data,
    output logic                    rd_en,
    output gpu_mem_pkg::byte_addr_t rd_addr
);
    import gpu_cmd_pkg::*;
    import gpu_mem_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        RECV_PARAMS,
        RECEIVE_DATA,
        SEND_DATA,
        KERNEL_RUN
    } ctrl_state_e;

    ctrl_state_e state;
    ctrl_state_e state_n;
    cmd_op_e     op;
    cmd_op_e     op_n;

    // slot being filled, and slot of the final parameter
    param_idx_t param_pos;
    param_idx_t param_pos_n;
    param_idx_t last_pos;
    param_idx_t last_pos_n;

    word_t params [MAX_PARAMS];
    // captured slots plus the word on in_data this cycle
    word_t params_n [MAX_PARAMS];

    // next address to touch, and the exclusive end of the range
    // compared with != so a range crossing 2^32 still terminates
    byte_addr_t data_addr;
    byte_addr_t data_addr_n;
    byte_addr_t end_addr;
    byte_addr_t end_addr_n;

    // read issued last cycle, its word is on rd_data now
    logic rd_pending;

    logic       launch_n;
    byte_addr_t kernel_addr_n;

    logic       last_param;
    byte_addr_t copy_addr;
    byte_addr_t copy_end;
    word_t      copy_count;

    assign busy = (state != IDLE);

    assign last_param = (state == RECV_PARAMS) && (param_pos == last_pos);

    // overlay the incoming parameter on the stored slots
    always_comb begin
        params_n = params;
        if (state == RECV_PARAMS) begin
            params_n[param_pos] = in_data;
        end
    end

    // slot 0 is the address for every command
    assign copy_addr  = byte_addr_t'(params_n[0]);
    assign copy_count = params_n[1];
    assign copy_end   = copy_addr + byte_addr_t'(copy_count);

    always_comb begin
        state_n       = state;
        op_n          = op;
        param_pos_n   = param_pos;
        last_pos_n    = last_pos;
        data_addr_n   = data_addr;
        end_addr_n    = end_addr;
        launch_n      = 1'b0;
        kernel_addr_n = kernel_addr;

        // memory strobes default off, address follows the walk
        wr_en   = 1'b0;
        wr_addr = data_addr;
        wr_data = in_data;
        rd_en   = 1'b0;
        rd_addr = data_addr;

        case (state)
            IDLE: begin
                op_n        = cmd_op_e'(recv_instr);
                param_pos_n = '0;
                // NOP and unknown opcodes have no parameters, stay idle
                if (param_count(cmd_op_e'(recv_instr)) != 0) begin
                    last_pos_n = param_idx_t'(param_count(cmd_op_e'(recv_instr)) - 1);
                    state_n    = RECV_PARAMS;
                end
            end

            RECV_PARAMS: begin
                param_pos_n = param_pos + 1'b1;
                if (param_pos == last_pos) begin
                    case (op)
                        COPY_TO_GPU: begin
                            data_addr_n = copy_addr;
                            end_addr_n  = copy_end;
                            // zero-length copy ends here
                            if (copy_count == '0) begin
                                state_n = IDLE;
                            end else begin
                                state_n = RECEIVE_DATA;
                            end
                        end
                        COPY_FROM_GPU: begin
                            end_addr_n = copy_end;
                            if (copy_count == '0) begin
                                state_n = IDLE;
                            end else begin
                                // first read goes out with the count word
                                rd_en       = 1'b1;
                                rd_addr     = copy_addr;
                                data_addr_n = copy_addr + BYTES_PER_WORD;
                                state_n     = SEND_DATA;
                            end
                        end
                        KERNEL_LAUNCH: begin
                            launch_n      = 1'b1;
                            kernel_addr_n = copy_addr;
                            state_n       = KERNEL_RUN;
                        end
                        default: begin
                            state_n = IDLE;
                        end
                    endcase
                end
            end

            RECEIVE_DATA: begin
                // one host word per cycle, written on this edge
                wr_en       = 1'b1;
                data_addr_n = data_addr + BYTES_PER_WORD;
                if (data_addr_n == end_addr) begin
                    state_n = IDLE;
                end
            end

            SEND_DATA: begin
                // keep issuing reads back to back until the range is covered
                if (data_addr != end_addr) begin
                    rd_en       = 1'b1;
                    data_addr_n = data_addr + BYTES_PER_WORD;
                end else if (!rd_pending) begin
                    // last word is on out_data this cycle
                    state_n = IDLE;
                end
            end

            KERNEL_RUN: begin
                if (kernel_done) begin
                    state_n = IDLE;
                end
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= IDLE;
            op          <= NOP;
            param_pos   <= '0;
            last_pos    <= '0;
            data_addr   <= '0;
            end_addr    <= '0;
            rd_pending  <= 1'b0;
            out_valid   <= 1'b0;
            out_data    <= '0;
            launch      <= 1'b0;
            kernel_addr <= '0;
        end else begin
            state       <= state_n;
            op          <= op_n;
            param_pos   <= param_pos_n;
            last_pos    <= last_pos_n;
            data_addr   <= data_addr_n;
            end_addr    <= end_addr_n;
            // one stage to cover the memory read latency
            rd_pending  <= rd_en;
            out_valid   <= rd_pending;
            if (rd_pending) begin
                out_data <= rd_data;
            end
            launch      <= launch_n;
            // held until the next launch
            kernel_addr <= kernel_addr_n;
        end
    end

    // parameter slots
    always_ff @(posedge clk) begin
        params <= params_n;
    end

    // copy counts are whole words, never rounded
    assert property (@(posedge clk) disable iff (!rst)
        last_param && (op == COPY_TO_GPU || op == COPY_FROM_GPU)
        |-> copy_count[WORD_SHIFT-1:0] == '0);

    // host keeps recv_instr at NOP for the whole command
    assert property (@(posedge clk) disable iff (!rst)
        busy |-> recv_instr == NOP);

    // launch is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst)
        launch |=> !launch);

endmodule

`default_nettype wire

// File: verilog/global_mem.sv
// Global word memory of the GPU.
// Single port pair: a synchronous write and a registered read, both
// addressed in bytes as the host sees them. The byte address is turned
// into a word index and folded into the depth, so addresses past the
// end wrap around. Read data shows one cycle after rd_en and holds
// until the next read.

`default_nettype none

module global_mem #(
    parameter int unsigned MEM_WORDS = 512
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  gpu_mem_pkg::byte_addr_t wr_addr,
    input  gpu_cmd_pkg::word_t      wr_data,
    input  logic                    rd_en,
    input  gpu_mem_pkg::byte_addr_t rd_addr,
    output gpu_cmd_pkg::word_t      rd_data
);
    import gpu_cmd_pkg::*;
    import gpu_mem_pkg::*;

    // at least one index bit even for a single-word memory
    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef logic [IDX_W-1:0] mem_idx_t;

    word_t mem [MEM_WORDS];

    word_idx_t wr_word;
    word_idx_t rd_word;
    mem_idx_t  wr_idx;
    mem_idx_t  rd_idx;

    // drop byte offset bits
    assign wr_word = word_idx_t'(wr_addr >> WORD_SHIFT);
    assign rd_word = word_idx_t'(rd_addr >> WORD_SHIFT);

    // wrap modulo depth, a plain bit slice when depth is a power of two
    assign wr_idx = mem_idx_t'(wr_word % MEM_WORDS);
    assign rd_idx = mem_idx_t'(rd_word % MEM_WORDS);

    // storage, contents undefined after reset
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read port
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

    // the controller only ever walks whole words
    assert property (@(posedge clk) disable iff (!rst)
        (!wr_en || wr_addr[WORD_SHIFT-1:0] == '0) &&
        (!rd_en || rd_addr[WORD_SHIFT-1:0] == '0));

endmodule

`default_nettype wire

// File: verilog/gpu_top.sv
// Top level of the GPU host interface.
// Joins the command controller to the global memory and sets the
// memory depth. The host drives recv_instr and in_data, reads
// out_data on out_valid, and answers launch with kernel_done.

`default_nettype none

module gpu_top #(
    // depth of global memory in words
    parameter int unsigned MEM_WORDS = 512
) (
    input  logic                    clk,
    input  logic                    rst,
    input  gpu_cmd_pkg::word_t      recv_instr,
    input  gpu_cmd_pkg::word_t      in_data,
    input  logic                    kernel_done,
    output gpu_cmd_pkg::word_t      out_data,
    output logic                    out_valid,
    output logic                    busy,
    output logic                    launch,
    output gpu_mem_pkg::byte_addr_t kernel_addr
);
    import gpu_cmd_pkg::*;
    import gpu_mem_pkg::*;

    // controller to memory
    logic       wr_en;
    byte_addr_t wr_addr;
    word_t      wr_data;
    logic       rd_en;
    byte_addr_t rd_addr;
    word_t      rd_data;

    controller controller_inst (
        .clk         (clk),
        .rst         (rst),
        .recv_instr  (recv_instr),
        .in_data     (in_data),
        .kernel_done (kernel_done),
        .rd_data     (rd_data),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .busy        (busy),
        .launch      (launch),
        .kernel_addr (kernel_addr),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr)
    );

    global_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) global_mem_inst (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: dv/tb_gpu_top.sv
// Directed testbench for the GPU host interface.
// Acts as the host driver: sends opcodes, parameters and copy-in words,
// collects copy-out words and answers kernel launches with kernel_done.
// Expected memory contents come from a reference model of every word
// written, indexed the way the host sees byte addresses wrap.

`default_nettype none

module tb_gpu_top;
    import gpu_cmd_pkg::*;
    import gpu_mem_pkg::*;

    localparam int unsigned MEM_WORDS = 512;
    localparam int RESET_CYCLES = 10;
    // copy-in plus copy-out data words over all tests
    localparam int WORDS_SENT = 81;
    localparam int NUM_TESTS = 6;
    localparam int LAUNCHES = 2;
    localparam int MAX_WAIT = 50;
    localparam int TIMEOUT =
        (WORDS_SENT + MAX_WAIT * LAUNCHES + 40 * NUM_TESTS + RESET_CYCLES) * 20;

    logic       clk;
    logic       rst;
    word_t      recv_instr;
    word_t      in_data;
    logic       kernel_done;
    word_t      out_data;
    logic       out_valid;
    logic       busy;
    logic       launch;
    byte_addr_t kernel_addr;

    // reference memory, key is the wrapped word index
    word_t ref_mem [int unsigned];
    string test_name;

    gpu_top #(
        .MEM_WORDS (MEM_WORDS)
    ) gpu_top_inst (
        .clk         (clk),
        .rst         (rst),
        .recv_instr  (recv_instr),
        .in_data     (in_data),
        .kernel_done (kernel_done),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .busy        (busy),
        .launch      (launch),
        .kernel_addr (kernel_addr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // one clock, then settle past the edge where outputs are stable
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // byte address to wrapped word index
    function automatic int unsigned word_index(logic [31:0] byte_addr);
        return (byte_addr >> 2) % MEM_WORDS;
    endfunction

    // opcode for one cycle, then back to NOP
    task automatic issue(word_t op);
        recv_instr = op;
        tick();
        recv_instr = NOP;
        check_val("busy after opcode", 1, busy);
    endtask

    task automatic copy_to_gpu(logic [31:0] addr, int nwords);
        word_t w;
        issue(COPY_TO_GPU);
        in_data = addr;
        tick();
        check_val("busy before count", 1, busy);
        in_data = word_t'(nwords * 4);
        tick();
        for (int i = 0; i < nwords; i++) begin
            check_val("busy during copy-in", 1, busy);
            w = $urandom();
            ref_mem[word_index(addr + 32'(4 * i))] = w;
            in_data = w;
            tick();
        end
        in_data = '0;
        // falls one cycle after the last word, or right after the count
        check_val("busy after copy-in", 0, busy);
        check_val("out_valid after copy-in", 0, out_valid);
    endtask

    task automatic copy_from_gpu(logic [31:0] addr, int nwords);
        int unsigned idx;
        issue(COPY_FROM_GPU);
        in_data = addr;
        tick();
        check_val("busy before count", 1, busy);
        in_data = word_t'(nwords * 4);
        tick();
        in_data = '0;
        if (nwords == 0) begin
            check_val("busy after empty copy-out", 0, busy);
            for (int i = 0; i < 4; i++) begin
                check_val("out_valid on empty copy-out", 0, out_valid);
                tick();
            end
        end else begin
            // read in flight, nothing out yet
            check_val("out_valid before data", 0, out_valid);
            check_val("busy before data", 1, busy);
            for (int i = 0; i < nwords; i++) begin
                tick();
                idx = word_index(addr + 32'(4 * i));
                check_val("out_valid during copy-out", 1, out_valid);
                check_val("busy during copy-out", 1, busy);
                assert (ref_mem.exists(idx)) else begin
                    $display("copy-out in %s reads word index %0d that was never written",
                             test_name, idx);
                    $display("STATUS: FAIL");
                    $fatal(1);
                end
                check_val("out_data", ref_mem[idx], out_data);
            end
            tick();
            // exactly nwords strobes
            check_val("out_valid after copy-out", 0, out_valid);
            check_val("busy after copy-out", 0, busy);
        end
    endtask

    task automatic launch_kernel(logic [31:0] kaddr, int wait_cycles);
        issue(KERNEL_LAUNCH);
        check_val("launch before parameter", 0, launch);
        in_data = kaddr;
        tick();
        in_data = '0;
        check_val("launch pulse", 1, launch);
        check_val("kernel_addr", kaddr, kernel_addr);
        for (int i = 0; i < wait_cycles; i++) begin
            tick();
            check_val("launch held low", 0, launch);
            check_val("busy while kernel runs", 1, busy);
            check_val("kernel_addr held", kaddr, kernel_addr);
        end
        kernel_done = 1'b1;
        tick();
        kernel_done = 1'b0;
        check_val("busy after kernel_done", 0, busy);
        check_val("launch after kernel_done", 0, launch);
    endtask

    task automatic test_reset_idle();
        test_name = "reset_idle";
        check_val("busy", 0, busy);
        check_val("out_valid", 0, out_valid);
        check_val("launch", 0, launch);
        check_val("out_data", 0, out_data);
        check_val("kernel_addr", 0, kernel_addr);
        for (int i = 0; i < 3; i++) begin
            tick();
            check_val("busy on NOP", 0, busy);
        end
        // unknown opcode is dropped
        recv_instr = 32'd7;
        tick();
        recv_instr = NOP;
        check_val("busy on unknown opcode", 0, busy);
        tick();
        check_val("busy after unknown opcode", 0, busy);
    endtask

    task automatic test_copy_in_out();
        test_name = "copy_in_out";
        copy_to_gpu(32'h40, 16);
        copy_from_gpu(32'h40, 16);
    endtask

    task automatic test_partial_wrap();
        test_name = "partial_wrap";
        copy_to_gpu(32'h100, 8);
        // overlaps the upper half of the last range
        copy_to_gpu(32'h110, 8);
        // past the end, lands on index 64
        copy_to_gpu(32'h900, 3);
        // crosses the top of memory into index 0
        copy_to_gpu(32'h7f8, 4);
        copy_from_gpu(32'h100, 12);
        copy_from_gpu(32'h7f8, 4);
    endtask

    task automatic test_zero_length();
        test_name = "zero_length";
        copy_to_gpu(32'h300, 0);
        copy_from_gpu(32'h300, 0);
    endtask

    task automatic test_kernel_launch();
        byte_addr_t kaddr;
        test_name = "kernel_launch";
        kaddr = 32'h0000_2a40;
        // stray done with no launch, nothing launched so far
        kernel_done = 1'b1;
        tick();
        kernel_done = 1'b0;
        check_val("busy on stray done", 0, busy);
        check_val("launch on stray done", 0, launch);
        check_val("kernel_addr on stray done", 0, kernel_addr);
        launch_kernel(kaddr, 1 + int'($urandom() % MAX_WAIT));
        kernel_done = 1'b1;
        tick();
        kernel_done = 1'b0;
        check_val("busy on late done", 0, busy);
        check_val("launch on late done", 0, launch);
        check_val("kernel_addr on late done", kaddr, kernel_addr);
    endtask

    task automatic test_back_to_back();
        test_name = "back_to_back";
        copy_to_gpu(32'h200, 5);
        launch_kernel(32'h0000_1000, 1 + int'($urandom() % MAX_WAIT));
        copy_from_gpu(32'h200, 5);
    endtask

    initial begin
        #(TIMEOUT);
        $display("watchdog expired after %0d time units, DUT stopped responding", TIMEOUT);
        $display("STATUS: FAIL");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h77bf_2bef));
        rst = 1'b0;
        recv_instr = NOP;
        in_data = '0;
        kernel_done = 1'b0;
        test_name = "none";
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b1;

        test_reset_idle();
        test_copy_in_out();
        test_partial_wrap();
        test_zero_length();
        test_kernel_launch();
        test_back_to_back();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: gpu_top.f
verilog/gpu_cmd_pkg.sv
verilog/gpu_mem_pkg.sv
verilog/controller.sv
verilog/global_mem.sv
verilog/gpu_top.sv
dv/tb_gpu_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the gpu_top testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f gpu_top.f \
    --top-module tb_gpu_top \
    -Mdir obj_dir \
    -o sim_gpu_top

# a failing run ends in $fatal, the log decides the result
./obj_dir/sim_gpu_top > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation failed"
    exit 1
fi
